// File: include/rob_defs.svh
`ifndef ROB_DEFS_SVH
`define ROB_DEFS_SVH

// data and address word
`define ROB_XLEN 32

// architectural register number
`define ROB_REG_ADDR_W 5

`define ROB_KIND_W 2

`endif

// File: design/rob_pkg.sv
`include "rob_defs.svh"

package rob_pkg;

    // data and address width
    localparam int XLEN = `ROB_XLEN;

    // architectural register number
    localparam int REG_ADDR_W = `ROB_REG_ADDR_W;

    localparam int KIND_W = `ROB_KIND_W;

    // entry kinds with code 3 left spare
    localparam logic [KIND_W-1:0] KIND_ALU    = KIND_W'(0);
    localparam logic [KIND_W-1:0] KIND_BRANCH = KIND_W'(1);
    localparam logic [KIND_W-1:0] KIND_STORE  = KIND_W'(2);

endpackage

// File: design/arch_reg_file.sv
module arch_reg_file
    import rob_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,

    input  logic                  commit_en,
    input  logic [REG_ADDR_W-1:0] commit_rd,
    input  logic [XLEN-1:0]       commit_value,

    input  logic [REG_ADDR_W-1:0] rs_addr,
    output logic [XLEN-1:0]       rs_value
);

    localparam int NUM_REGS = 2 ** REG_ADDR_W;

    // x0 has no storage
    logic [XLEN-1:0] regs_q [1:NUM_REGS-1];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < NUM_REGS; i++) begin
                regs_q[i] <= '0;
            end
        end else if (commit_en && commit_rd != '0) begin
            regs_q[commit_rd] <= commit_value;
        end
    end

    assign rs_value = (rs_addr == '0) ? '0 : regs_q[rs_addr];

endmodule

// File: design/rename_table.sv
module rename_table
    import rob_pkg::*;
#(
    parameter int ROB_DEPTH = 16,
    parameter int TAG_W     = $clog2(ROB_DEPTH)
) (
    input  logic                  clk,
    input  logic                  rst_n,

    input  logic                  alloc_en,
    input  logic                  full,
    input  logic [REG_ADDR_W-1:0] alloc_rd,
    input  logic [TAG_W-1:0]      alloc_tag,

    input  logic                  commit_en,
    input  logic [REG_ADDR_W-1:0] commit_rd,
    input  logic [TAG_W-1:0]      commit_tag,
    input  logic                  flush,

    input  logic [REG_ADDR_W-1:0] rs_addr,
    output logic                  rs_busy,
    output logic [TAG_W-1:0]      rs_tag
);

    localparam int NUM_REGS = 2 ** REG_ADDR_W;

    logic [NUM_REGS-1:0] busy_q;
    // newest producer of each register
    logic [TAG_W-1:0]    tag_q [NUM_REGS];

    logic                alloc_set;
    logic                commit_clr;

    // x0 never gets a producer
    assign alloc_set  = alloc_en && !full && (alloc_rd != '0);
    assign commit_clr = commit_en && (tag_q[commit_rd] == commit_tag);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_q <= '0;
        end else if (flush) begin
            busy_q <= '0;
        end else begin
            if (commit_clr) begin
                busy_q[commit_rd] <= 1'b0;
            end
            // younger allocation overrides the release
            if (alloc_set) begin
                busy_q[alloc_rd] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (alloc_set) begin
            tag_q[alloc_rd] <= alloc_tag;
        end
    end

    assign rs_busy = busy_q[rs_addr];
    assign rs_tag  = tag_q[rs_addr];

endmodule

// File: design/reorder_buffer.sv
module reorder_buffer
    import rob_pkg::*;
#(
    parameter int ROB_DEPTH = 16,
    parameter int TAG_W     = $clog2(ROB_DEPTH)
) (
    input  logic                  clk,
    input  logic                  rst_n,

    // allocation from decode
    input  logic                  alloc_en,
    input  logic [REG_ADDR_W-1:0] alloc_rd,
    input  logic [KIND_W-1:0]     alloc_kind,
    input  logic                  alloc_pred_taken,
    output logic [TAG_W-1:0]      alloc_tag,
    output logic                  full,

    // completion from execution
    input  logic                  wb_en,
    input  logic [TAG_W-1:0]      wb_tag,
    input  logic [XLEN-1:0]       wb_value,
    input  logic                  wb_taken,
    input  logic [XLEN-1:0]       wb_target,

    // commit
    output logic                  commit_en,
    output logic [REG_ADDR_W-1:0] commit_rd,
    output logic [XLEN-1:0]       commit_value,
    output logic [TAG_W-1:0]      commit_tag,
    output logic                  redirect_en,
    output logic [XLEN-1:0]       redirect_pc,
    output logic                  flush,

    // store unit
    output logic                  store_release,
    output logic [TAG_W-1:0]      store_tag,
    input  logic                  store_ack,

    // operand forwarding
    input  logic [TAG_W-1:0]      fwd_tag,
    output logic                  fwd_ready,
    output logic [XLEN-1:0]       fwd_value
);

    // per-entry control
    logic [ROB_DEPTH-1:0]  valid_q;
    logic [ROB_DEPTH-1:0]  done_q;

    // per-entry payload
    logic [KIND_W-1:0]     kind_q   [ROB_DEPTH];
    logic [REG_ADDR_W-1:0] rd_q     [ROB_DEPTH];
    logic [XLEN-1:0]       value_q  [ROB_DEPTH];
    logic                  pred_q   [ROB_DEPTH];
    logic                  taken_q  [ROB_DEPTH];
    logic [XLEN-1:0]       target_q [ROB_DEPTH];

    logic [TAG_W-1:0]      head;
    logic [TAG_W-1:0]      tail;
    // one extra bit so a full buffer is distinct from empty
    logic [TAG_W:0]        count;

    logic                  alloc_fire;
    logic                  head_ready;
    logic                  retire;

    assign full       = count[TAG_W];
    assign alloc_tag  = tail;
    assign alloc_fire = alloc_en && !full;

    assign head_ready = valid_q[head] && done_q[head];

    // commit decision on the head entry
    always_comb begin
        commit_en     = 1'b0;
        redirect_en   = 1'b0;
        store_release = 1'b0;
        if (head_ready) begin
            case (kind_q[head])
                KIND_ALU: begin
                    commit_en = 1'b1;
                end
                KIND_BRANCH: begin
                    commit_en   = 1'b1;
                    redirect_en = taken_q[head] != pred_q[head];
                end
                KIND_STORE: begin
                    store_release = 1'b1;
                end
                default: begin
                    // spare code retires like an alu op
                    commit_en = 1'b1;
                end
            endcase
        end
    end

    assign commit_rd    = rd_q[head];
    assign commit_value = value_q[head];
    assign commit_tag   = head;
    assign redirect_pc  = target_q[head];
    assign store_tag    = head;

    // mispredict empties the buffer at the same edge
    assign flush  = redirect_en;
    assign retire = commit_en || (store_release && store_ack);

    assign fwd_ready = valid_q[fwd_tag] && done_q[fwd_tag];
    assign fwd_value = value_q[fwd_tag];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= '0;
            done_q  <= '0;
            head    <= '0;
            tail    <= '0;
            count   <= '0;
        end else if (flush) begin
            valid_q <= '0;
            done_q  <= '0;
            head    <= '0;
            tail    <= '0;
            count   <= '0;
        end else begin
            if (alloc_fire) begin
                valid_q[tail] <= 1'b1;
                done_q[tail]  <= 1'b0;
                tail          <= tail + TAG_W'(1);
            end
            if (wb_en) begin
                done_q[wb_tag] <= 1'b1;
            end
            if (retire) begin
                valid_q[head] <= 1'b0;
                head          <= head + TAG_W'(1);
            end
            count <= count + (TAG_W+1)'(alloc_fire) - (TAG_W+1)'(retire);
        end
    end

    // payload written at allocate and completion
    always_ff @(posedge clk) begin
        if (alloc_fire) begin
            kind_q[tail] <= alloc_kind;
            rd_q[tail]   <= alloc_rd;
            pred_q[tail] <= alloc_pred_taken;
        end
        if (wb_en) begin
            value_q[wb_tag]  <= wb_value;
            taken_q[wb_tag]  <= wb_taken;
            target_q[wb_tag] <= wb_target;
        end
    end

endmodule

// File: design/retire_unit.sv
module retire_unit
    import rob_pkg::*;
#(
    parameter  int ROB_DEPTH = 16,
    localparam int TAG_W     = $clog2(ROB_DEPTH)
) (
    input  logic                  clk,
    input  logic                  rst_n,

    input  logic                  alloc_en,
    input  logic [REG_ADDR_W-1:0] alloc_rd,
    input  logic [KIND_W-1:0]     alloc_kind,
    input  logic                  alloc_pred_taken,
    output logic [TAG_W-1:0]      alloc_tag,
    output logic                  full,

    input  logic                  wb_en,
    input  logic [TAG_W-1:0]      wb_tag,
    input  logic [XLEN-1:0]       wb_value,
    input  logic                  wb_taken,
    input  logic [XLEN-1:0]       wb_target,

    output logic                  commit_en,
    output logic [REG_ADDR_W-1:0] commit_rd,
    output logic [XLEN-1:0]       commit_value,
    output logic [TAG_W-1:0]      commit_tag,
    output logic                  redirect_en,
    output logic [XLEN-1:0]       redirect_pc,

    output logic                  store_release,
    output logic [TAG_W-1:0]      store_tag,
    input  logic                  store_ack,

    input  logic [REG_ADDR_W-1:0] rs_addr,
    output logic [XLEN-1:0]       rs_value,
    output logic                  rs_busy,
    output logic [TAG_W-1:0]      rs_tag,
    output logic                  rs_fwd_ready,
    output logic [XLEN-1:0]       rs_fwd_value
);

    logic flush;

    reorder_buffer #(
        .ROB_DEPTH (ROB_DEPTH),
        .TAG_W     (TAG_W)
    ) i_rob (
        .clk              (clk),
        .rst_n            (rst_n),
        .alloc_en         (alloc_en),
        .alloc_rd         (alloc_rd),
        .alloc_kind       (alloc_kind),
        .alloc_pred_taken (alloc_pred_taken),
        .alloc_tag        (alloc_tag),
        .full             (full),
        .wb_en            (wb_en),
        .wb_tag           (wb_tag),
        .wb_value         (wb_value),
        .wb_taken         (wb_taken),
        .wb_target        (wb_target),
        .commit_en        (commit_en),
        .commit_rd        (commit_rd),
        .commit_value     (commit_value),
        .commit_tag       (commit_tag),
        .redirect_en      (redirect_en),
        .redirect_pc      (redirect_pc),
        .flush            (flush),
        .store_release    (store_release),
        .store_tag        (store_tag),
        .store_ack        (store_ack),
        .fwd_tag          (rs_tag),
        .fwd_ready        (rs_fwd_ready),
        .fwd_value        (rs_fwd_value)
    );

    rename_table #(
        .ROB_DEPTH (ROB_DEPTH),
        .TAG_W     (TAG_W)
    ) i_rename (
        .clk        (clk),
        .rst_n      (rst_n),
        .alloc_en   (alloc_en),
        .full       (full),
        .alloc_rd   (alloc_rd),
        .alloc_tag  (alloc_tag),
        .commit_en  (commit_en),
        .commit_rd  (commit_rd),
        .commit_tag (commit_tag),
        .flush      (flush),
        .rs_addr    (rs_addr),
        .rs_busy    (rs_busy),
        .rs_tag     (rs_tag)
    );

    arch_reg_file i_regs (
        .clk          (clk),
        .rst_n        (rst_n),
        .commit_en    (commit_en),
        .commit_rd    (commit_rd),
        .commit_value (commit_value),
        .rs_addr      (rs_addr),
        .rs_value     (rs_value)
    );

endmodule

// File: dv/retire_assert.sv
module retire_assert #(
    parameter int TAG_W = 4
) (
    input logic             clk,
    input logic             rst_n,
    input logic             alloc_en,
    input logic [TAG_W-1:0] alloc_tag,
    input logic             full,
    input logic             commit_en,
    input logic             redirect_en,
    input logic             store_release
);

    // store hand-off and register commit are exclusive
    commit_store_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(commit_en && store_release))
        else $error("commit_en and store_release high together");

    redirect_needs_commit: assert property (@(posedge clk) disable iff (!rst_n)
        redirect_en |-> commit_en)
        else $error("redirect_en without commit_en");

    // a flush resets the tail, so it is excluded
    full_holds_tag: assert property (@(posedge clk) disable iff (!rst_n)
        full && alloc_en && !redirect_en |=> $stable(alloc_tag))
        else $error("alloc_tag moved on an allocation while full");

endmodule

bind retire_unit retire_assert #(
    .TAG_W (TAG_W)
) i_retire_assert (
    .clk           (clk),
    .rst_n         (rst_n),
    .alloc_en      (alloc_en),
    .alloc_tag     (alloc_tag),
    .full          (full),
    .commit_en     (commit_en),
    .redirect_en   (redirect_en),
    .store_release (store_release)
);

// File: dv/retire_tb.sv
module retire_tb
    import rob_pkg::*;
();

    localparam int DEPTH     = 8;
    localparam int TW        = $clog2(DEPTH);
    localparam int PERIOD    = 40;
    localparam int NUM_TESTS = 5;
    localparam int N_INSTR   = 40;

    typedef struct packed {
        logic [TW-1:0]         tag;
        logic [KIND_W-1:0]     kind;
        logic [REG_ADDR_W-1:0] rd;
        logic                  pred;
        logic                  done;
        logic                  taken;
        logic [XLEN-1:0]       value;
        logic [XLEN-1:0]       target;
    } rob_entry_t;

    typedef struct packed {
        logic                  en;
        logic                  redirect;
        logic                  store_rel;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       value;
        logic [TW-1:0]         tag;
        logic [XLEN-1:0]       pc;
    } commit_t;

    logic clk, rst_n;
    logic alloc_en, alloc_pred_taken, full;
    logic [REG_ADDR_W-1:0] alloc_rd, commit_rd, rs_addr;
    logic [KIND_W-1:0] alloc_kind;
    logic [TW-1:0] alloc_tag, wb_tag, commit_tag, store_tag, rs_tag;
    logic wb_en, wb_taken, commit_en, redirect_en, store_release, store_ack;
    logic rs_busy, rs_fwd_ready;
    logic [XLEN-1:0] wb_value, wb_target, commit_value, redirect_pc;
    logic [XLEN-1:0] rs_value, rs_fwd_value;

    // reference model state
    rob_entry_t      model [$];
    logic [XLEN-1:0] reg_img [32];
    logic [TW-1:0]   tail_m;
    int              accepted;
    int              tests, checks, errors;

    retire_unit #(.ROB_DEPTH(DEPTH)) i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(NUM_TESTS * N_INSTR * 40 * PERIOD);
        $display("watchdog expired before all tests finished");
        $display("=== FAIL ===");
        $finish;
    end

    task automatic check_value(input string name, input logic [31:0] exp_v,
                               input logic [31:0] act_v);
        checks++;
        if (act_v !== exp_v) begin
            errors++;
            $display("[ERROR] %0t %s expected %h actual %h", $time, name, exp_v, act_v);
        end
    endtask

    // expected commit behavior of the head entry
    function automatic commit_t ref_commit(input logic have, input rob_entry_t e);
        commit_t c;
        c = '0;
        if (have && e.done) begin
            if (e.kind == KIND_STORE) begin
                c.store_rel = 1'b1;
            end else begin
                c.en       = 1'b1;
                c.redirect = (e.kind == KIND_BRANCH) && (e.taken != e.pred);
            end
            c.rd    = e.rd;
            c.value = e.value;
            c.tag   = e.tag;
            c.pc    = e.target;
        end
        return c;
    endfunction

    task automatic compare_cycle();
        commit_t    exp;
        rob_entry_t e;
        rob_entry_t ne;
        logic       full_exp;
        int         prod;
        e        = (model.size() != 0) ? model[0] : '0;
        exp      = ref_commit(model.size() != 0, e);
        full_exp = (model.size() == DEPTH);
        check_value("commit_en", 32'(exp.en), 32'(commit_en));
        check_value("redirect_en", 32'(exp.redirect), 32'(redirect_en));
        check_value("store_release", 32'(exp.store_rel), 32'(store_release));
        check_value("full", 32'(full_exp), 32'(full));
        if (exp.en) begin
            check_value("commit_rd", 32'(exp.rd), 32'(commit_rd));
            check_value("commit_value", exp.value, commit_value);
            check_value("commit_tag", 32'(exp.tag), 32'(commit_tag));
        end
        if (exp.redirect)
            check_value("redirect_pc", exp.pc, redirect_pc);
        if (exp.store_rel)
            check_value("store_tag", 32'(exp.tag), 32'(store_tag));
        // youngest in-flight producer of the looked-up register
        prod = -1;
        foreach (model[i])
            if (rs_addr != '0 && model[i].rd == rs_addr) prod = i;
        check_value("rs_busy", 32'(prod >= 0), 32'(rs_busy));
        check_value("rs_value", reg_img[rs_addr], rs_value);
        if (prod >= 0) begin
            check_value("rs_tag", 32'(model[prod].tag), 32'(rs_tag));
            check_value("rs_fwd_ready", 32'(model[prod].done), 32'(rs_fwd_ready));
            if (model[prod].done)
                check_value("rs_fwd_value", model[prod].value, rs_fwd_value);
        end
        if (exp.en && e.rd != '0) reg_img[e.rd] = e.value;
        if (exp.redirect) begin
            model.delete();
            tail_m = '0;
        end else begin
            if (exp.en || (exp.store_rel && store_ack)) void'(model.pop_front());
            if (wb_en) begin
                foreach (model[i]) begin
                    if (model[i].tag == wb_tag) begin
                        model[i].done   = 1'b1;
                        model[i].value  = wb_value;
                        model[i].taken  = wb_taken;
                        model[i].target = wb_target;
                    end
                end
            end
            if (alloc_en && !full_exp) begin
                check_value("alloc_tag", 32'(tail_m), 32'(alloc_tag));
                ne      = '0;
                ne.tag  = tail_m;
                ne.kind = alloc_kind;
                ne.rd   = alloc_rd;
                ne.pred = alloc_pred_taken;
                model.push_back(ne);
                tail_m = tail_m + TW'(1);
                accepted++;
            end
        end
    endtask

    initial begin
        forever begin
            @(posedge clk);
            if (rst_n) compare_cycle();
        end
    end

    task automatic run_test(input string name, input int br_pct, input int st_pct,
                            input int wb_pct, input int rd_lim);
        int start_err;
        int k;
        int pick;
        int open_idx [$];
        start_err = errors;
        accepted  = 0;
        while (accepted < N_INSTR || model.size() != 0) begin
            @(negedge clk);
            k = $urandom % 100;
            alloc_en   = (accepted < N_INSTR) && ($urandom % 100 < 70);
            alloc_kind = (k < br_pct) ? KIND_BRANCH :
                         (k < br_pct + st_pct) ? KIND_STORE : KIND_ALU;
            // stores name no destination
            alloc_rd = (alloc_kind == KIND_STORE) ? '0 : REG_ADDR_W'($urandom % rd_lim);
            alloc_pred_taken = 1'($urandom);
            open_idx.delete();
            foreach (model[i])
                if (!model[i].done) open_idx.push_back(i);
            wb_en = (open_idx.size() != 0) && ($urandom % 100 < wb_pct);
            if (wb_en) begin
                pick      = open_idx[$urandom % open_idx.size()];
                wb_tag    = model[pick].tag;
                wb_taken  = ($urandom % 4 == 0) ? !model[pick].pred : model[pick].pred;
                wb_value  = $urandom;
                wb_target = $urandom;
            end
            store_ack = ($urandom % 3 == 0);
            rs_addr   = REG_ADDR_W'($urandom % rd_lim);
        end
        tests++;
        $display("test %-10s %0d instructions, %0d errors", name, N_INSTR, errors - start_err);
    endtask

    initial begin
        void'($urandom(32'hd64ce871));
        {alloc_en, alloc_pred_taken, wb_en, wb_taken, store_ack} = '0;
        alloc_rd   = '0;
        alloc_kind = KIND_ALU;
        wb_tag     = '0;
        wb_value   = '0;
        wb_target  = '0;
        rs_addr    = '0;
        tail_m     = '0;
        foreach (reg_img[i]) reg_img[i] = '0;
        rst_n = 1'b0;
        repeat (16) @(negedge clk);
        rst_n = 1'b1;
        run_test("alu_order", 0, 0, 50, 32);
        run_test("full", 0, 0, 5, 32);
        run_test("operands", 0, 0, 40, 4);
        run_test("branches", 50, 0, 40, 8);
        run_test("stores", 0, 40, 40, 8);
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// File: filelist.f
+incdir+include
design/rob_pkg.sv
design/arch_reg_file.sv
design/rename_table.sv
design/reorder_buffer.sv
design/retire_unit.sv
dv/retire_assert.sv
dv/retire_tb.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        := retire_tb
FILELIST   := filelist.f
OBJ_DIR    := obj_dir
VFLAGS     := --binary --timing --assert --Mdir $(OBJ_DIR)
LINT_FLAGS := --lint-only --timing --assert

.PHONY: all run lint clean

all: run

run:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q '^=== PASS ===$$'

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
